// File: Bender.yml
package:
  name: dds_tone

sources:
  - include_dirs:
      - logic
    files:
      - logic/dds_pkg.sv
      - logic/tone_config_regs.sv
      - logic/dds_sample_pipeline.sv
      - logic/wave_shaper.sv
      - logic/dds_tone_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/dds_tone_tb.sv

// File: flist.f
+incdir+logic
logic/dds_pkg.sv
logic/tone_config_regs.sv
logic/dds_sample_pipeline.sv
logic/wave_shaper.sv
logic/dds_tone_top.sv
verif/dds_tone_tb.sv

// File: logic/dds_pkg.sv
package dds_pkg;

   ////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////
   localparam int PHASE_W        = 16;           // phase accumulator and tuning word
   localparam int SAMPLE_W       = 12;           // offset binary sample
   localparam int KEY_ID_W       = 7;
   localparam int NUM_KEYS       = 8;            // bit 7 never set
   localparam int SINE_QTR_DEPTH = 64;

   // key ids, also bitmap positions
   localparam logic [KEY_ID_W-1:0] KEY_1    = 7'd0;
   localparam logic [KEY_ID_W-1:0] KEY_2    = 7'd1;
   localparam logic [KEY_ID_W-1:0] KEY_3    = 7'd2;
   localparam logic [KEY_ID_W-1:0] KEY_4    = 7'd3;
   localparam logic [KEY_ID_W-1:0] KEY_5    = 7'd4;
   localparam logic [KEY_ID_W-1:0] KEY_UP   = 7'd5;
   localparam logic [KEY_ID_W-1:0] KEY_DOWN = 7'd6;

   // encoding follows KEY_1..KEY_5
   typedef enum logic [2:0] {
      WAVE_SINE     = 3'd0,
      WAVE_SQUARE   = 3'd1,
      WAVE_SAW      = 3'd2,
      WAVE_TRIANGLE = 3'd3,
      WAVE_NOISE    = 3'd4
   } wave_sel_t;

   localparam logic [PHASE_W-1:0] TUNE_DEFAULT = 16'd256;
   localparam logic [PHASE_W-1:0] TUNE_STEP    = 16'd64;
   localparam logic [PHASE_W-1:0] TUNE_MIN     = 16'd64;
   localparam logic [PHASE_W-1:0] TUNE_MAX     = 16'd4096;

   // x^16 + x^15 + x^13 + x^4 + 1, as register bit positions
   localparam logic [PHASE_W-1:0] LFSR_SEED  = 16'hace1;
   localparam int                 LFSR_TAP_A = 15;
   localparam int                 LFSR_TAP_B = 14;
   localparam int                 LFSR_TAP_C = 12;
   localparam int                 LFSR_TAP_D = 3;

   typedef struct packed {
      logic                brk;                  // 1 = key released
      logic [KEY_ID_W-1:0] key_id;
   } key_event_s;

   typedef union packed {
      logic [7:0] raw;
      key_event_s fields;
   } key_event_u;

endpackage

// File: logic/dds_sample_pipeline.sv
`timescale 1ns/1ps

module dds_sample_pipeline (
   input  logic                          CLK_25MHZ,
   input  logic                          reset_from_key,
   input  logic [dds_pkg::PHASE_W-1:0]   tuning_word,
   input  logic [dds_pkg::SAMPLE_W-1:0]  shaped,
   input  logic                          sample_ready,
   output logic [dds_pkg::PHASE_W-1:0]   phase,
   output logic [dds_pkg::PHASE_W-1:0]   noise,
   output logic                          sample_valid,
   output logic [dds_pkg::SAMPLE_W-1:0]  sample
);

   logic                         load;
   logic                         lfsr_fb;
   logic [dds_pkg::PHASE_W-1:0]  lfsr_next;

   // empty or draining this edge
   assign load = !sample_valid || sample_ready;

   ////////////////////////////////////////////////////
   // noise LFSR step
   ////////////////////////////////////////////////////
   assign lfsr_fb   = noise[dds_pkg::LFSR_TAP_A] ^ noise[dds_pkg::LFSR_TAP_B]
                    ^ noise[dds_pkg::LFSR_TAP_C] ^ noise[dds_pkg::LFSR_TAP_D];
   assign lfsr_next = {noise[dds_pkg::PHASE_W-2:0], lfsr_fb};   // shift left, fb into bit 0

   // phase, LFSR and valid advance only on a load
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase        <= '0;
         noise        <= dds_pkg::LFSR_SEED;
         sample_valid <= 1'b0;
      end
      else if (load)
      begin
         phase        <= phase + tuning_word;   // wraps mod 2^16
         noise        <= lfsr_next;
         sample_valid <= 1'b1;                  // sticky until reset
      end
   end

   ////////////////////////////////////////////////////
   // output sample register
   ////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (load)
      begin
         sample <= shaped;   // holds under back-pressure
      end
   end

endmodule

// File: logic/dds_tone_top.sv
`timescale 1ns/1ps

module dds_tone_top (
   input  logic                          CLK_25MHZ,
   input  logic                          reset_from_key,
   input  logic                          key_event_valid,
   input  logic [7:0]                    key_event,
   input  logic                          sample_ready,
   output logic [dds_pkg::NUM_KEYS-1:0]  held_keys,
   output logic                          sample_valid,
   output logic [dds_pkg::SAMPLE_W-1:0]  sample
);

   dds_pkg::wave_sel_t             wave_sel;
   logic [dds_pkg::PHASE_W-1:0]    tuning_word;
   logic [dds_pkg::PHASE_W-1:0]    phase;
   logic [dds_pkg::PHASE_W-1:0]    noise;
   logic [dds_pkg::SAMPLE_W-1:0]   shaped;

   ////////////////////////////////////////////////////
   // key events to config registers
   ////////////////////////////////////////////////////
   tone_config_regs u_config (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event_valid(key_event_valid),
      .key_event      (key_event),        // raw byte into the union
      .held_keys      (held_keys),
      .wave_sel       (wave_sel),
      .tuning_word    (tuning_word)
   );

   dds_sample_pipeline u_pipe (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tuning_word    (tuning_word),
      .shaped         (shaped),
      .sample_ready   (sample_ready),
      .phase          (phase),
      .noise          (noise),
      .sample_valid   (sample_valid),
      .sample         (sample)
   );

   wave_shaper u_shaper (
      .phase   (phase),
      .noise   (noise),
      .wave_sel(wave_sel),
      .shaped  (shaped)                   // back into the output register
   );

endmodule

// File: logic/sine_quarter_table.svh
// first quadrant of a 2047 amplitude sine, sampled at half-step offsets
localparam logic [10:0] SINE_QTR [0:dds_pkg::SINE_QTR_DEPTH-1] = '{
   11'd25,
   11'd75,
   11'd126,
   11'd176,
   11'd226,
   11'd275,
   11'd325,
   11'd375,
   11'd424,
   11'd473,
   11'd522,
   11'd570,
   11'd618,
   11'd666,
   11'd713,
   11'd760,
   11'd807,
   11'd852,
   11'd898,
   11'd943,
   11'd987,
   11'd1031,
   11'd1074,
   11'd1116,
   11'd1158,
   11'd1199,
   11'd1239,
   11'd1279,
   11'd1318,
   11'd1356,
   11'd1393,
   11'd1430,
   11'd1465,
   11'd1500,
   11'd1533,
   11'd1566,
   11'd1598,
   11'd1629,
   11'd1659,
   11'd1688,
   11'd1716,
   11'd1743,
   11'd1769,
   11'd1793,
   11'd1817,
   11'd1840,
   11'd1861,
   11'd1881,
   11'd1901,
   11'd1919,
   11'd1936,
   11'd1951,
   11'd1966,
   11'd1979,
   11'd1992,
   11'd2003,
   11'd2012,
   11'd2021,
   11'd2028,
   11'd2035,
   11'd2039,
   11'd2043,
   11'd2046,
   11'd2047
};

// File: logic/tone_config_regs.sv
`timescale 1ns/1ps

module tone_config_regs (
   input  logic                          CLK_25MHZ,
   input  logic                          reset_from_key,
   input  logic                          key_event_valid,
   input  dds_pkg::key_event_u           key_event,
   output logic [dds_pkg::NUM_KEYS-1:0]  held_keys,
   output dds_pkg::wave_sel_t            wave_sel,
   output logic [dds_pkg::PHASE_W-1:0]   tuning_word
);

   logic                           is_break;
   logic [dds_pkg::KEY_ID_W-1:0]   key_id;
   logic                           key_known;

   assign is_break  = key_event.fields.brk;
   assign key_id    = key_event.fields.key_id;
   assign key_known = (key_id <= dds_pkg::KEY_DOWN);   // ids 7 and up dropped

   ////////////////////////////////////////////////////
   // held-key bitmap
   ////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else if (key_event_valid && key_known)
      begin
         held_keys[key_id[2:0]] <= ~is_break;    // make sets, break clears
      end
   end

   ////////////////////////////////////////////////////
   // waveform and tuning, make events only
   ////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_sel    <= dds_pkg::WAVE_SINE;
         tuning_word <= dds_pkg::TUNE_DEFAULT;
      end
      else if (key_event_valid && key_known && !is_break)
      begin
         if (key_id == dds_pkg::KEY_UP)
         begin
            if (tuning_word >= dds_pkg::TUNE_MAX - dds_pkg::TUNE_STEP)
               tuning_word <= dds_pkg::TUNE_MAX;    // clamp high
            else
               tuning_word <= tuning_word + dds_pkg::TUNE_STEP;
         end
         else if (key_id == dds_pkg::KEY_DOWN)
         begin
            if (tuning_word <= dds_pkg::TUNE_MIN + dds_pkg::TUNE_STEP)
               tuning_word <= dds_pkg::TUNE_MIN;    // clamp low
            else
               tuning_word <= tuning_word - dds_pkg::TUNE_STEP;
         end
         else
         begin
            wave_sel <= dds_pkg::wave_sel_t'(key_id[2:0]);   // number keys 1..5
         end
      end
   end

endmodule

// File: logic/wave_shaper.sv
`timescale 1ns/1ps

module wave_shaper (
   input  logic [dds_pkg::PHASE_W-1:0]   phase,
   input  logic [dds_pkg::PHASE_W-1:0]   noise,
   input  dds_pkg::wave_sel_t            wave_sel,
   output logic [dds_pkg::SAMPLE_W-1:0]  shaped
);

`include "sine_quarter_table.svh"

   logic [1:0]                    quadrant;
   logic [5:0]                    idx;
   logic [5:0]                    idx_fold;
   logic [10:0]                   tbl_val;
   logic [dds_pkg::SAMPLE_W-1:0]  sine_s;
   logic [dds_pkg::SAMPLE_W-1:0]  square_s;
   logic [dds_pkg::SAMPLE_W-1:0]  saw_s;
   logic [dds_pkg::SAMPLE_W-1:0]  tri_s;
   logic [dds_pkg::SAMPLE_W-1:0]  noise_s;

   ////////////////////////////////////////////////////
   // sine by quadrant folding
   ////////////////////////////////////////////////////
   assign quadrant = phase[15:14];
   assign idx      = phase[13:8];
   assign idx_fold = quadrant[0] ? (6'd63 - idx) : idx;   // odd quadrants run backwards
   assign tbl_val  = SINE_QTR[idx_fold];

   // upper half above mid-scale, lower half mirrored below
   assign sine_s = quadrant[1] ? (12'd2047 - {1'b0, tbl_val})
                               : (12'd2048 + {1'b0, tbl_val});

   assign square_s = phase[15] ? '0 : '1;
   assign saw_s    = phase[15:4];
   assign tri_s    = phase[15] ? ~phase[14:3] : phase[14:3];   // falling on second half
   assign noise_s  = noise[15:4];

   always_comb
   begin
      case (wave_sel)
         dds_pkg::WAVE_SQUARE:   shaped = square_s;
         dds_pkg::WAVE_SAW:      shaped = saw_s;
         dds_pkg::WAVE_TRIANGLE: shaped = tri_s;
         dds_pkg::WAVE_NOISE:    shaped = noise_s;
         default:                shaped = sine_s;
      endcase
   end

endmodule

// File: verif/dds_tone_tb.sv
`timescale 1ns/1ps

module dds_tone_tb;

`include "sine_quarter_table.svh"

   localparam int NUM_ROWS    = 8;
   localparam int MAX_N       = 80;
   localparam int CYCLE_LIMIT = NUM_ROWS * (4 + 4 + 2 * MAX_N) * 4;

   logic                           CLK_25MHZ;
   logic                           reset_from_key;
   logic                           key_event_valid;
   logic [7:0]                     key_event;
   logic                           sample_ready;
   logic [dds_pkg::NUM_KEYS-1:0]   held_keys;
   logic                           sample_valid;
   logic [dds_pkg::SAMPLE_W-1:0]   sample;

   // stimulus table, one entry per row
   int          row_nev  [NUM_ROWS];
   logic [7:0]  row_ev   [NUM_ROWS][4];
   logic [2:0]  row_wave [NUM_ROWS];
   logic [15:0] row_tune [NUM_ROWS];
   logic [7:0]  row_held [NUM_ROWS];
   int          row_n    [NUM_ROWS];
   bit          row_rand [NUM_ROWS];

   int     error_count;
   int     cycle_count;
   integer seed;
   integer rnd_word;

   dds_tone_top dut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event_valid(key_event_valid),
      .key_event      (key_event),
      .sample_ready   (sample_ready),
      .held_keys      (held_keys),
      .sample_valid   (sample_valid),
      .sample         (sample)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz
   end

   always @(posedge CLK_25MHZ)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////
   function automatic logic [15:0] lfsr_step(input logic [15:0] l);
      logic fb;
      fb = l[15] ^ l[14] ^ l[12] ^ l[3];   // exponents 16 15 13 4, less one
      return {l[14:0], fb};
   endfunction

   function automatic logic [11:0] model_shape(input logic [15:0] p,
                                               input logic [15:0] lfsr,
                                               input logic [2:0]  wave);
      logic [5:0]  i;
      logic [11:0] t_fwd;
      logic [11:0] t_rev;
      i     = p[13:8];
      t_fwd = {1'b0, SINE_QTR[i]};
      t_rev = {1'b0, SINE_QTR[6'd63 - i]};
      if (wave == dds_pkg::WAVE_SAW)
         return p[15:4];
      if (wave == dds_pkg::WAVE_SQUARE)
         return (p[15] == 1'b0) ? 12'hfff : 12'h000;
      if (wave == dds_pkg::WAVE_TRIANGLE)
         return (p[15] == 1'b0) ? p[14:3] : ~p[14:3];
      if (wave == dds_pkg::WAVE_NOISE)
         return lfsr[15:4];
      case (p[15:14])
         2'd0:    return 12'd2048 + t_fwd;
         2'd1:    return 12'd2048 + t_rev;
         2'd2:    return 12'd2047 - t_fwd;
         default: return 12'd2047 - t_rev;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("Error: t=%0t %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic set_row(input int r, input int nev, input logic [7:0] e0,
                          input logic [7:0] e1, input logic [7:0] e2, input logic [7:0] e3,
                          input logic [2:0] wave, input logic [15:0] tune,
                          input logic [7:0] held, input int n, input bit rnd);
      row_nev[r]   = nev;
      row_ev[r][0] = e0;
      row_ev[r][1] = e1;
      row_ev[r][2] = e2;
      row_ev[r][3] = e3;
      row_wave[r]  = wave;
      row_tune[r]  = tune;
      row_held[r]  = held;
      row_n[r]     = n;
      row_rand[r]  = rnd;
   endtask

   task automatic apply_reset();
      @(posedge CLK_25MHZ);
      reset_from_key  <= 1'b1;
      sample_ready    <= 1'b0;
      key_event_valid <= 1'b0;
      repeat (4) @(posedge CLK_25MHZ);
      reset_from_key  <= 1'b0;
   endtask

   ////////////////////////////////////////////////////
   // one table row
   ////////////////////////////////////////////////////
   task automatic run_row(input int r);
      int          xfer;
      int          err_before;
      logic [15:0] m_phase;
      logic [15:0] m_lfsr;
      logic [11:0] expect_s;
      err_before = error_count;
      apply_reset();
      for (int e = 0; e < row_nev[r]; e++)
      begin
         @(posedge CLK_25MHZ);
         key_event_valid <= 1'b1;
         key_event       <= row_ev[r][e];
      end
      @(posedge CLK_25MHZ);
      key_event_valid <= 1'b0;
      key_event       <= 8'h00;
      @(negedge CLK_25MHZ);
      check_value("held_keys", row_held[r], held_keys);

      // the stale load ran on the reset tuning word and took one LFSR step
      m_phase = dds_pkg::TUNE_DEFAULT;
      m_lfsr  = lfsr_step(dds_pkg::LFSR_SEED);
      xfer    = 0;
      while (xfer <= row_n[r])
      begin
         @(posedge CLK_25MHZ);
         if (row_rand[r])
         begin
            rnd_word = $random(seed);
            sample_ready <= rnd_word[0];
         end
         else
            sample_ready <= 1'b1;
         @(negedge CLK_25MHZ);
         check_value("sample_valid", 1, sample_valid);   // sticky after first load
         if (sample_valid && sample_ready)
         begin
            if (xfer > 0)
            begin
               expect_s = model_shape(m_phase, m_lfsr, row_wave[r]);
               check_value("sample", expect_s, sample);
               m_phase = m_phase + row_tune[r];   // wraps mod 2^16
               m_lfsr  = lfsr_step(m_lfsr);
            end
            xfer++;
         end
      end
      @(posedge CLK_25MHZ);
      sample_ready <= 1'b0;
      $display("row %0d done: %0d transfers checked, %0d mismatches",
               r, row_n[r], error_count - err_before);
   endtask

   initial
   begin
      reset_from_key  = 1'b1;
      key_event_valid = 1'b0;
      key_event       = 8'h00;
      sample_ready    = 1'b0;
      error_count     = 0;
      cycle_count     = 0;
      seed            = 32'h3761;

      set_row(0, 0, 8'h00, 8'h00, 8'h00, 8'h00, dds_pkg::WAVE_SINE,     16'd256, 8'h00, 24, 0);
      set_row(1, 4, 8'h01, 8'h02, 8'h81, 8'h09, dds_pkg::WAVE_SAW,      16'd256, 8'h04, 24, 0);
      set_row(2, 4, 8'h01, 8'h05, 8'h05, 8'h05, dds_pkg::WAVE_SQUARE,   16'd448, 8'h22, 80, 0);
      set_row(3, 3, 8'h02, 8'h05, 8'h05, 8'h00, dds_pkg::WAVE_SAW,      16'd384, 8'h24, 40, 0);
      set_row(4, 4, 8'h03, 8'h05, 8'h05, 8'h05, dds_pkg::WAVE_TRIANGLE, 16'd448, 8'h28, 80, 0);
      set_row(5, 4, 8'h06, 8'h06, 8'h06, 8'h06, dds_pkg::WAVE_SINE,     16'd64,  8'h40, 40, 0);
      set_row(6, 1, 8'h04, 8'h00, 8'h00, 8'h00, dds_pkg::WAVE_NOISE,    16'd256, 8'h10, 24, 0);
      set_row(7, 4, 8'h00, 8'h05, 8'h05, 8'h85, dds_pkg::WAVE_SINE,     16'd384, 8'h01, 80, 1);

      for (int r = 0; r < NUM_ROWS; r++)
         run_row(r);

      $display("rows run: %0d, errors: %0d", NUM_ROWS, error_count);
      if (error_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
